// ==== src/atomics_pkg.sv ====
// atomics package
// shared widths, writedata field positions, atomic op codes and
// the payload types carried by the pending-read and writeback queues

`default_nettype none

package atomics_pkg;

  // memory port geometry
  localparam int ADDR_WIDTH = 27;
  localparam int DATA_WIDTH = 128;
  localparam int BYTEEN_WIDTH = 16;

  // atomic operands are always 32-bit, one segment of the word
  localparam int OPERATION_WIDTH = 32;
  localparam int SEGMENT_BITS = 2;
  localparam int SEGMENT_BYTES = OPERATION_WIDTH / 8;
  localparam int ATOMIC_OP_WIDTH = 3;

  // slots and queue depths
  localparam int NUM_TXS = 4;
  localparam int TX_BITS = 2;
  localparam int PENDING_DEPTH = 8;
  localparam int WRITEBACK_DEPTH = 4;

  // writedata layout of an atomic request
  localparam int ATOMIC_FLAG_BIT = 0;
  localparam int OPERAND0_LSB = 1;
  localparam int OPERAND1_LSB = 33;
  localparam int ATOMIC_OP_LSB = 65;
  localparam int SEGMENT_LSB = 68;

  // one bit per op code, all eight built
  localparam logic [7:0] USED_ATOMIC_OPERATIONS = 8'b1111_1111;

  typedef enum logic [ATOMIC_OP_WIDTH-1:0] {
    ATOMIC_ADD     = 3'd0,
    ATOMIC_XCHG    = 3'd1,
    ATOMIC_CMPXCHG = 3'd2,
    ATOMIC_MIN     = 3'd3,
    ATOMIC_MAX     = 3'd4,
    ATOMIC_AND     = 3'd5,
    ATOMIC_OR      = 3'd6,
    ATOMIC_XOR     = 3'd7
  } atomic_op_e;

  // one read sent to memory, waiting for its response
  typedef struct packed {
    logic                       is_atomic;
    logic [TX_BITS-1:0]         tx;
    atomic_op_e                 op;
    logic [ADDR_WIDTH-1:0]      address;
    logic [SEGMENT_BITS-1:0]    segment;
    logic [OPERATION_WIDTH-1:0] operand0;
    logic [OPERATION_WIDTH-1:0] operand1;
  } pending_t;

  // one atomic result waiting to be written back
  typedef struct packed {
    logic [TX_BITS-1:0]         tx;
    logic [ADDR_WIDTH-1:0]      address;
    logic [SEGMENT_BITS-1:0]    segment;
    logic [OPERATION_WIDTH-1:0] result;
  } writeback_t;

endpackage

`default_nettype wire

// ==== src/tx_fifo.sv ====
// small synchronous queue
// circular buffer with a count; the entry type is a type parameter
// so the same queue holds pending reads and atomic writebacks

`timescale 1ns/1ps
`default_nettype none

module tx_fifo #(
  parameter type payload_t = logic,
  parameter int DEPTH = 4
) (
  input  logic     clock,
  input  logic     resetn,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t head,
  output logic     not_empty,
  output logic     full
);

  // storage, payload only
  payload_t mem [DEPTH];

  // pointers wrap naturally, depth is a power of two
  logic [$clog2(DEPTH)-1:0] wr_ptr;
  logic [$clog2(DEPTH)-1:0] rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;
  logic do_push;
  logic do_pop;

  // push into a full queue or pop from an empty one is dropped
  assign do_push = push && !full;
  assign do_pop = pop && not_empty;

  assign not_empty = (count != '0);
  assign full = (count == DEPTH);
  assign head = mem[rd_ptr];

  always_ff @(posedge clock) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      // count moves only when exactly one side acts
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/atomic_alu.sv ====
// atomic ALU
// combinational 32-bit operation on the old memory value and the operands;
// ops left out of the used-operation mask are not built

`timescale 1ns/1ps
`default_nettype none

module atomic_alu (
  input  logic [atomics_pkg::OPERATION_WIDTH-1:0] readdata,
  input  atomics_pkg::atomic_op_e                 atomic_op,
  input  logic [atomics_pkg::OPERATION_WIDTH-1:0] operand0,
  input  logic [atomics_pkg::OPERATION_WIDTH-1:0] operand1,
  output logic [atomics_pkg::OPERATION_WIDTH-1:0] atomic_out
);

  // result of every op code, unused ones tied to zero
  logic [atomics_pkg::OPERATION_WIDTH-1:0] op_result [8];

  function automatic logic [atomics_pkg::OPERATION_WIDTH-1:0] compute(
    input atomics_pkg::atomic_op_e op,
    input logic [atomics_pkg::OPERATION_WIDTH-1:0] rd,
    input logic [atomics_pkg::OPERATION_WIDTH-1:0] op0,
    input logic [atomics_pkg::OPERATION_WIDTH-1:0] op1
  );
    case (op)
      atomics_pkg::ATOMIC_ADD: compute = rd + op0;
      atomics_pkg::ATOMIC_XCHG: compute = op0;
      // swap only on a match, otherwise keep memory as is
      atomics_pkg::ATOMIC_CMPXCHG: compute = (rd == op0) ? op1 : rd;
      // min and max compare unsigned
      atomics_pkg::ATOMIC_MIN: compute = (rd < op0) ? rd : op0;
      atomics_pkg::ATOMIC_MAX: compute = (rd > op0) ? rd : op0;
      atomics_pkg::ATOMIC_AND: compute = rd & op0;
      atomics_pkg::ATOMIC_OR: compute = rd | op0;
      default: compute = rd ^ op0;
    endcase
  endfunction

  // one constant-op instance per used code
  for (genvar i = 0; i < 8; i++) begin : g_op
    if (atomics_pkg::USED_ATOMIC_OPERATIONS[i]) begin : g_used
      assign op_result[i] = compute(atomics_pkg::atomic_op_e'(i), readdata, operand0, operand1);
    end else begin : g_unused
      assign op_result[i] = '0;
    end
  end

  assign atomic_out = op_result[atomic_op];

endmodule

`default_nettype wire

// ==== src/atomic_tx_table.sv ====
// atomic transaction table
// decodes arbiter requests, tracks up to four atomics in flight,
// finds conflicts against them and raises waitrequest on a stall

`timescale 1ns/1ps
`default_nettype none

module atomic_tx_table (
  input  logic                                   clock,
  input  logic                                   resetn,
  input  logic                                   arb_read,
  input  logic                                   arb_write,
  input  logic [atomics_pkg::ADDR_WIDTH-1:0]     arb_address,
  input  logic [atomics_pkg::DATA_WIDTH-1:0]     arb_writedata,
  input  logic [atomics_pkg::BYTEEN_WIDTH-1:0]   arb_byteenable,
  input  logic                                   avm_waitrequest,
  input  logic                                   wb_send,
  input  logic                                   pending_full,
  input  logic                                   wb_taken,
  input  atomics_pkg::writeback_t                wb_entry,
  output logic                                   arb_waitrequest,
  output logic                                   read_grant,
  output logic                                   write_grant,
  output atomics_pkg::pending_t                  pending_entry
);

  // slot state: valid is control, address and segment are payload
  logic [atomics_pkg::NUM_TXS-1:0] slot_valid;
  logic [atomics_pkg::ADDR_WIDTH-1:0] slot_address [atomics_pkg::NUM_TXS];
  logic [atomics_pkg::SEGMENT_BITS-1:0] slot_segment [atomics_pkg::NUM_TXS];

  logic is_atomic;
  logic [atomics_pkg::SEGMENT_BITS-1:0] req_segment;
  logic free_found;
  logic [atomics_pkg::TX_BITS-1:0] free_idx;
  logic conflict;
  logic read_hold;
  logic write_hold;

  // an atomic is a read with the flag bit set
  assign is_atomic = arb_read && arb_writedata[atomics_pkg::ATOMIC_FLAG_BIT];
  assign req_segment = arb_writedata[atomics_pkg::SEGMENT_LSB +: atomics_pkg::SEGMENT_BITS];

  // lowest free slot
  always_comb begin
    free_found = 1'b0;
    free_idx = '0;
    for (int i = 0; i < atomics_pkg::NUM_TXS; i++) begin
      if (!slot_valid[i] && !free_found) begin
        free_found = 1'b1;
        free_idx = atomics_pkg::TX_BITS'(i);
      end
    end
  end

  // same word and byteenable touching the slot's four segment bytes
  always_comb begin
    conflict = 1'b0;
    for (int i = 0; i < atomics_pkg::NUM_TXS; i++) begin
      if (slot_valid[i] && (slot_address[i] == arb_address) &&
          ((arb_byteenable & (atomics_pkg::BYTEEN_WIDTH'({atomics_pkg::SEGMENT_BYTES{1'b1}})
            << (slot_segment[i] * atomics_pkg::SEGMENT_BYTES))) != '0)) begin
        conflict = 1'b1;
      end
    end
  end

  // reads yield to a writeback on the port; plain reads skip the conflict check
  assign read_hold = avm_waitrequest || wb_send || pending_full ||
                     (is_atomic && (!free_found || conflict));
  // plain writes beat writebacks, only conflicts and memory stall them
  assign write_hold = avm_waitrequest || conflict;

  assign read_grant = arb_read && !read_hold;
  assign write_grant = arb_write && !write_hold;
  assign arb_waitrequest = (arb_read && read_hold) || (arb_write && write_hold);

  // everything the response side needs once the data comes back
  always_comb begin
    pending_entry.is_atomic = is_atomic;
    pending_entry.tx = free_idx;
    pending_entry.op = atomics_pkg::atomic_op_e'(
      arb_writedata[atomics_pkg::ATOMIC_OP_LSB +: atomics_pkg::ATOMIC_OP_WIDTH]);
    pending_entry.address = arb_address;
    pending_entry.segment = req_segment;
    pending_entry.operand0 = arb_writedata[atomics_pkg::OPERAND0_LSB +: atomics_pkg::OPERATION_WIDTH];
    pending_entry.operand1 = arb_writedata[atomics_pkg::OPERAND1_LSB +: atomics_pkg::OPERATION_WIDTH];
  end

  // fill and free never hit the same slot in one cycle
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      slot_valid <= '0;
    end else begin
      if (wb_taken) slot_valid[wb_entry.tx] <= 1'b0;
      if (read_grant && is_atomic) slot_valid[free_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (read_grant && is_atomic) begin
      slot_address[free_idx] <= arb_address;
      slot_segment[free_idx] <= req_segment;
    end
  end

endmodule

`default_nettype wire

// ==== src/atomic_response_path.sv ====
// atomic response path
// returns memory responses in request order, runs the ALU on atomic
// responses and queues the results for writeback

`timescale 1ns/1ps
`default_nettype none

module atomic_response_path (
  input  logic                               clock,
  input  logic                               resetn,
  input  logic                               read_grant,
  input  atomics_pkg::pending_t              pending_entry,
  input  logic [atomics_pkg::DATA_WIDTH-1:0] avm_readdata,
  input  logic                               avm_readdatavalid,
  input  logic                               wb_taken,
  output logic                               pending_full,
  output logic [atomics_pkg::DATA_WIDTH-1:0] arb_readdata,
  output logic                               arb_readdatavalid,
  output logic                               wb_valid,
  output atomics_pkg::writeback_t            wb_entry
);

  atomics_pkg::pending_t pend_head;
  atomics_pkg::writeback_t wb_new;
  logic pend_not_empty;
  logic resp_atomic;
  logic [atomics_pkg::OPERATION_WIDTH-1:0] seg_data;
  logic [atomics_pkg::OPERATION_WIDTH-1:0] alu_out;

  // reads in flight, oldest at the head
  tx_fifo #(
    .payload_t(atomics_pkg::pending_t),
    .DEPTH(atomics_pkg::PENDING_DEPTH)
  ) pending_q (
    .clock(clock),
    .resetn(resetn),
    .push(read_grant),
    .push_data(pending_entry),
    .pop(avm_readdatavalid),
    .head(pend_head),
    .not_empty(pend_not_empty),
    .full(pending_full)
  );

  // memory answers in order, so the head owns this response
  assign arb_readdata = avm_readdata;
  assign arb_readdatavalid = avm_readdatavalid;
  assign resp_atomic = avm_readdatavalid && pend_not_empty && pend_head.is_atomic;

  // old value of the addressed segment
  assign seg_data = avm_readdata[pend_head.segment * atomics_pkg::OPERATION_WIDTH +:
                                 atomics_pkg::OPERATION_WIDTH];

  atomic_alu alu_i (
    .readdata(seg_data),
    .atomic_op(pend_head.op),
    .operand0(pend_head.operand0),
    .operand1(pend_head.operand1),
    .atomic_out(alu_out)
  );

  // slot index and address ride along with the result
  always_comb begin
    wb_new.tx = pend_head.tx;
    wb_new.address = pend_head.address;
    wb_new.segment = pend_head.segment;
    wb_new.result = alu_out;
  end

  // at most four atomics in flight, so this never fills
  tx_fifo #(
    .payload_t(atomics_pkg::writeback_t),
    .DEPTH(atomics_pkg::WRITEBACK_DEPTH)
  ) writeback_q (
    .clock(clock),
    .resetn(resetn),
    .push(resp_atomic),
    .push_data(wb_new),
    .pop(wb_taken),
    .head(wb_entry),
    .not_empty(wb_valid),
    .full()
  );

endmodule

`default_nettype wire

// ==== src/atomic_mem_mux.sv ====
// memory port multiplexer
// picks between the plain arbiter request and the head writeback:
// plain write first, then atomic writeback, then granted read

`timescale 1ns/1ps
`default_nettype none

module atomic_mem_mux (
  input  logic                                 arb_read,
  input  logic                                 arb_write,
  input  logic [atomics_pkg::ADDR_WIDTH-1:0]   arb_address,
  input  logic [atomics_pkg::DATA_WIDTH-1:0]   arb_writedata,
  input  logic [atomics_pkg::BYTEEN_WIDTH-1:0] arb_byteenable,
  input  logic                                 wb_valid,
  input  atomics_pkg::writeback_t              wb_entry,
  input  logic                                 avm_waitrequest,
  input  logic                                 read_grant,
  input  logic                                 write_grant,
  output logic                                 avm_read,
  output logic                                 avm_write,
  output logic [atomics_pkg::ADDR_WIDTH-1:0]   avm_address,
  output logic [atomics_pkg::DATA_WIDTH-1:0]   avm_writedata,
  output logic [atomics_pkg::BYTEEN_WIDTH-1:0] avm_byteenable,
  output logic                                 wb_send,
  output logic                                 wb_taken
);

  logic write_on_port;

  // while memory stalls, keep the arbiter request on the port
  // a conflict-held write gives the port to the writeback
  assign write_on_port = arb_write && (write_grant || avm_waitrequest);
  assign wb_send = wb_valid && !write_on_port;
  assign wb_taken = wb_send && !avm_waitrequest;

  assign avm_read = arb_read && !wb_send && (read_grant || avm_waitrequest);
  assign avm_write = write_on_port || wb_send;

  // writeback is a single-segment write into the old word
  always_comb begin
    if (wb_send) begin
      avm_address = wb_entry.address;
      avm_writedata = atomics_pkg::DATA_WIDTH'(wb_entry.result)
                      << (wb_entry.segment * atomics_pkg::OPERATION_WIDTH);
      avm_byteenable = atomics_pkg::BYTEEN_WIDTH'({atomics_pkg::SEGMENT_BYTES{1'b1}})
                       << (wb_entry.segment * atomics_pkg::SEGMENT_BYTES);
    end else begin
      avm_address = arb_address;
      avm_writedata = arb_writedata;
      avm_byteenable = arb_byteenable;
    end
  end

endmodule

`default_nettype wire

// ==== src/atomic_handler.sv ====
// atomic handler top level
// sits between a local-memory arbiter and an in-order memory port;
// plain traffic passes through, atomics are read, computed and written back

`timescale 1ns/1ps
`default_nettype none

module atomic_handler (
  input  logic                                 clock,
  input  logic                                 resetn,
  // arbiter side
  input  logic                                 arb_read,
  input  logic                                 arb_write,
  input  logic [atomics_pkg::ADDR_WIDTH-1:0]   arb_address,
  input  logic [atomics_pkg::DATA_WIDTH-1:0]   arb_writedata,
  input  logic [atomics_pkg::BYTEEN_WIDTH-1:0] arb_byteenable,
  output logic                                 arb_waitrequest,
  output logic [atomics_pkg::DATA_WIDTH-1:0]   arb_readdata,
  output logic                                 arb_readdatavalid,
  // memory side
  output logic                                 avm_read,
  output logic                                 avm_write,
  output logic [atomics_pkg::ADDR_WIDTH-1:0]   avm_address,
  output logic [atomics_pkg::DATA_WIDTH-1:0]   avm_writedata,
  output logic [atomics_pkg::BYTEEN_WIDTH-1:0] avm_byteenable,
  input  logic                                 avm_waitrequest,
  input  logic [atomics_pkg::DATA_WIDTH-1:0]   avm_readdata,
  input  logic                                 avm_readdatavalid
);

  logic read_grant;
  logic write_grant;
  logic pending_full;
  logic wb_valid;
  logic wb_send;
  logic wb_taken;
  atomics_pkg::pending_t pending_entry;
  atomics_pkg::writeback_t wb_entry;

  // request side
  atomic_tx_table tx_table_i (
    .clock(clock),
    .resetn(resetn),
    .arb_read(arb_read),
    .arb_write(arb_write),
    .arb_address(arb_address),
    .arb_writedata(arb_writedata),
    .arb_byteenable(arb_byteenable),
    .avm_waitrequest(avm_waitrequest),
    .wb_send(wb_send),
    .pending_full(pending_full),
    .wb_taken(wb_taken),
    .wb_entry(wb_entry),
    .arb_waitrequest(arb_waitrequest),
    .read_grant(read_grant),
    .write_grant(write_grant),
    .pending_entry(pending_entry)
  );

  // response side
  atomic_response_path response_i (
    .clock(clock),
    .resetn(resetn),
    .read_grant(read_grant),
    .pending_entry(pending_entry),
    .avm_readdata(avm_readdata),
    .avm_readdatavalid(avm_readdatavalid),
    .wb_taken(wb_taken),
    .pending_full(pending_full),
    .arb_readdata(arb_readdata),
    .arb_readdatavalid(arb_readdatavalid),
    .wb_valid(wb_valid),
    .wb_entry(wb_entry)
  );

  // memory port
  atomic_mem_mux mem_mux_i (
    .arb_read(arb_read),
    .arb_write(arb_write),
    .arb_address(arb_address),
    .arb_writedata(arb_writedata),
    .arb_byteenable(arb_byteenable),
    .wb_valid(wb_valid),
    .wb_entry(wb_entry),
    .avm_waitrequest(avm_waitrequest),
    .read_grant(read_grant),
    .write_grant(write_grant),
    .avm_read(avm_read),
    .avm_write(avm_write),
    .avm_address(avm_address),
    .avm_writedata(avm_writedata),
    .avm_byteenable(avm_byteenable),
    .wb_send(wb_send),
    .wb_taken(wb_taken)
  );

endmodule

`default_nettype wire

// ==== bench/atomic_handler_assertions.sv ====
// atomic handler port assertions
// bound to the top level; checks the memory port and the arbiter handshake

`timescale 1ns/1ps
`default_nettype none

module atomic_handler_assertions (
  input logic clock,
  input logic resetn,
  input logic arb_read,
  input logic arb_write,
  input logic arb_waitrequest,
  input logic arb_readdatavalid,
  input logic avm_read,
  input logic avm_write,
  input logic avm_waitrequest,
  input logic avm_readdatavalid
);

  // failures seen, read by the testbench verdict
  int unsigned fail_count = 0;

  // one command on the memory port per cycle
  no_read_and_write: assert property (@(posedge clock) disable iff (!resetn)
    !(avm_read && avm_write))
  else begin
    $error("memory read and write asserted together");
    fail_count++;
  end

  // responses pass straight through
  valid_passthrough: assert property (@(posedge clock) disable iff (!resetn)
    arb_readdatavalid == avm_readdatavalid)
  else begin
    $error("arbiter readdatavalid differs from memory readdatavalid");
    fail_count++;
  end

  // a memory stall must reach a requesting arbiter
  stall_reaches_arbiter: assert property (@(posedge clock) disable iff (!resetn)
    (avm_waitrequest && (arb_read || arb_write)) |-> arb_waitrequest)
  else begin
    $error("memory waitrequest not passed to the arbiter");
    fail_count++;
  end

endmodule

`default_nettype wire

// ==== bench/atomic_handler_tb.sv ====
// atomic handler testbench
// drives a table of plain and atomic requests through the handler,
// models an in-order memory with random latency and stalls,
// and checks every returned value against a reference model

`timescale 1ns/1ps
`default_nettype none

module atomic_handler_tb;

  localparam int K_ATOMIC = 0;
  localparam int K_READ = 1;
  localparam int K_WRITE = 2;
  localparam int K_SYNC = 3;
  localparam int MEM_WORDS = 64;

  typedef struct packed {
    logic [1:0]  kind;
    logic [26:0] addr;
    logic [1:0]  seg;
    logic [2:0]  op;
    logic [31:0] op0;
    logic [31:0] op1;
    logic [31:0] expect_val;
  } entry_t;

  logic clock = 1'b0;
  logic resetn;
  logic arb_read;
  logic arb_write;
  logic [atomics_pkg::ADDR_WIDTH-1:0] arb_address;
  logic [atomics_pkg::DATA_WIDTH-1:0] arb_writedata;
  logic [atomics_pkg::BYTEEN_WIDTH-1:0] arb_byteenable;
  logic arb_waitrequest;
  logic [atomics_pkg::DATA_WIDTH-1:0] arb_readdata;
  logic arb_readdatavalid;
  logic avm_read;
  logic avm_write;
  logic [atomics_pkg::ADDR_WIDTH-1:0] avm_address;
  logic [atomics_pkg::DATA_WIDTH-1:0] avm_writedata;
  logic [atomics_pkg::BYTEEN_WIDTH-1:0] avm_byteenable;
  logic avm_waitrequest;
  logic [atomics_pkg::DATA_WIDTH-1:0] avm_readdata;
  logic avm_readdatavalid;

  // memory, reference copy and in-flight response queue
  logic [127:0] mem [MEM_WORDS];
  logic [127:0] ref_mem [MEM_WORDS];
  logic [127:0] resp_data [$];
  int resp_due [$];
  // expected returns in request order
  logic [31:0] exp_val [$];
  logic [1:0] exp_seg [$];
  string exp_name [$];
  entry_t table_q [$];
  string name_q [$];
  logic [31:0] lcg_state = 32'h94b5;
  int cycle = 0;
  int limit = 1000000;
  int errors = 0;
  int mem_writes = 0;
  int issued_writes = 0;

  atomic_handler dut_i (.*);

  bind atomic_handler atomic_handler_assertions assertions_i (.*);

  always #50 clock = ~clock;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  // starting contents differ per segment and depend on the whole address
  function automatic logic [31:0] init_seg(int a, int s);
    return (a * 32'h0100_0193) ^ (32'h5a5a_0000 + s * 32'h1111);
  endfunction

  // reference result of each op code with unsigned min and max
  function automatic logic [31:0] apply_op(logic [2:0] op, logic [31:0] old,
                                           logic [31:0] a, logic [31:0] b);
    case (op)
      3'd0: return old + a;
      3'd1: return a;
      3'd2: return (old == a) ? b : old;
      3'd3: return (old < a) ? old : a;
      3'd4: return (old > a) ? old : a;
      3'd5: return old & a;
      3'd6: return old | a;
      default: return old ^ a;
    endcase
  endfunction

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic add_entry(string name, int kind, int addr, int seg, int op,
                           logic [31:0] op0, logic [31:0] op1);
    entry_t e;
    logic [31:0] old;
    old = ref_mem[addr][seg*32 +: 32];
    e = '{kind[1:0], addr[26:0], seg[1:0], op[2:0], op0, op1, old};
    if (kind == K_ATOMIC) ref_mem[addr][seg*32 +: 32] = apply_op(op[2:0], old, op0, op1);
    if (kind == K_WRITE) ref_mem[addr][seg*32 +: 32] = op0;
    table_q.push_back(e);
    name_q.push_back(name);
  endtask

  // wait until every return came back and every write reached memory
  task automatic wait_idle();
    while (exp_val.size() != 0 || mem_writes != issued_writes) @(negedge clock);
  endtask

  // entered and left on a falling edge
  task automatic apply_entry(entry_t e, string name);
    logic done;
    if (e.kind == K_SYNC) begin
      wait_idle();
    end else begin
      arb_read = (e.kind != K_WRITE);
      arb_write = (e.kind == K_WRITE);
      arb_address = e.addr;
      arb_writedata = '0;
      arb_byteenable = 16'hf << (e.seg * 4);
      if (e.kind == K_READ) arb_byteenable = '1;
      if (e.kind == K_WRITE) arb_writedata = 128'(e.op0) << (e.seg * 32);
      if (e.kind == K_ATOMIC) begin
        arb_writedata[atomics_pkg::ATOMIC_FLAG_BIT] = 1'b1;
        arb_writedata[atomics_pkg::OPERAND0_LSB +: 32] = e.op0;
        arb_writedata[atomics_pkg::OPERAND1_LSB +: 32] = e.op1;
        arb_writedata[atomics_pkg::ATOMIC_OP_LSB +: 3] = e.op;
        arb_writedata[atomics_pkg::SEGMENT_LSB +: 2] = e.seg;
      end
      done = 1'b0;
      while (!done) begin
        @(posedge clock);
        done = !arb_waitrequest;
      end
      if (e.kind != K_WRITE) begin
        exp_val.push_back(e.expect_val);
        exp_seg.push_back(e.seg);
        exp_name.push_back(name);
      end
      if (e.kind != K_READ) issued_writes++;
      @(negedge clock);
      arb_read = 1'b0;
      arb_write = 1'b0;
    end
  endtask

  // memory outputs change on the falling edge
  always @(negedge clock) begin
    avm_waitrequest = resetn && (lcg_next() % 4 == 0);
    if (resp_due.size() != 0 && resp_due[0] <= cycle) begin
      avm_readdatavalid = 1'b1;
      avm_readdata = resp_data[0];
    end else begin
      avm_readdatavalid = 1'b0;
      avm_readdata = '0;
    end
  end

  // commands accepted at the rising edge and reads answered 1 to 4 cycles later
  always @(posedge clock) begin
    cycle++;
    if (avm_readdatavalid) begin
      void'(resp_due.pop_front());
      void'(resp_data.pop_front());
    end
    if (avm_read && !avm_waitrequest) begin
      resp_data.push_back(mem[avm_address % MEM_WORDS]);
      resp_due.push_back(cycle + int'(lcg_next() % 4));
    end
    if (avm_write && !avm_waitrequest) begin
      for (int b = 0; b < 16; b++) begin
        if (avm_byteenable[b]) mem[avm_address % MEM_WORDS][b*8 +: 8] = avm_writedata[b*8 +: 8];
      end
      mem_writes++;
    end
    if (cycle > limit) begin
      $display("run timed out after %0d cycles", cycle);
      $display("Simulation failed");
      $finish;
    end
  end

  // returned values in request order
  always @(posedge clock) begin
    if (arb_readdatavalid) begin
      if (exp_val.size() == 0) begin
        errors++;
        $display("a read response arrived with no request outstanding");
      end else begin
        check_value(exp_name[0], exp_val[0], arb_readdata[exp_seg[0]*32 +: 32]);
        void'(exp_val.pop_front());
        void'(exp_seg.pop_front());
        void'(exp_name.pop_front());
      end
    end
  end

  initial begin
    resetn = 1'b0;
    arb_read = 1'b0;
    arb_write = 1'b0;
    arb_address = '0;
    arb_writedata = '0;
    arb_byteenable = '0;
    avm_waitrequest = 1'b0;
    avm_readdata = '0;
    avm_readdatavalid = 1'b0;
    for (int a = 0; a < MEM_WORDS; a++) begin
      for (int s = 0; s < 4; s++) mem[a][s*32 +: 32] = init_seg(a, s);
      ref_mem[a] = mem[a];
    end
    // every op on its own address with cmpxchg both matching and not
    // operands carry the top bit so min and max see unsigned order
    for (int i = 0; i < 8; i++) begin
      add_entry($sformatf("op%0d", i), K_ATOMIC, i + 1, i % 4, i,
                32'h9234_5678 + i, 32'hcafe_0000);
    end
    add_entry("cmpxchg_hit", K_ATOMIC, 9, 1, 2, init_seg(9, 1), 32'hbeef_0009);
    add_entry("sync1", K_SYNC, 0, 0, 0, 0, 0);
    for (int i = 1; i <= 9; i++) begin
      add_entry($sformatf("result%0d", i), K_READ, i, (i - 1) % 4, 0, 0, 0);
    end
    add_entry("fix_seg", K_READ, 9, 1, 0, 0, 0);
    // serialized adds on one segment
    for (int i = 0; i < 3; i++) add_entry("add_chain", K_ATOMIC, 10, 1, 0, 32'd100 + i, 0);
    add_entry("sync2", K_SYNC, 0, 0, 0, 0, 0);
    add_entry("add_chain_final", K_READ, 10, 1, 0, 0, 0);
    // plain write held behind an atomic in flight
    add_entry("wb_before_write", K_ATOMIC, 11, 2, 0, 32'd7, 0);
    add_entry("held_write", K_WRITE, 11, 2, 0, 32'h600d_f00d, 0);
    add_entry("sync3", K_SYNC, 0, 0, 0, 0, 0);
    add_entry("write_final", K_READ, 11, 2, 0, 0, 0);
    // neighbouring segments untouched
    add_entry("seg_xor", K_ATOMIC, 12, 2, 7, 32'hffff_ffff, 0);
    add_entry("sync4", K_SYNC, 0, 0, 0, 0, 0);
    for (int s = 0; s < 4; s++) add_entry($sformatf("seg%0d", s), K_READ, 12, s, 0, 0, 0);
    // five atomics where the fifth needs a freed slot
    for (int i = 0; i < 5; i++) begin
      add_entry($sformatf("slot%0d", i), K_ATOMIC, 13 + i, i % 4, 0, 32'd5 * i + 1, 0);
    end
    add_entry("sync5", K_SYNC, 0, 0, 0, 0, 0);
    for (int i = 0; i < 5; i++) begin
      add_entry($sformatf("slot_final%0d", i), K_READ, 13 + i, i % 4, 0, 0, 0);
    end
    limit = 60 * table_q.size();

    repeat (4) @(posedge clock);
    @(negedge clock);
    resetn = 1'b1;
    @(negedge clock);
    for (int i = 0; i < table_q.size(); i++) apply_entry(table_q[i], name_q[i]);
    wait_idle();

    $display("errors: %0d check, %0d assertion", errors, dut_i.assertions_i.fail_count);
    if (errors == 0 && dut_i.assertions_i.fail_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== atomic_handler.f ====
src/atomics_pkg.sv
src/tx_fifo.sv
src/atomic_alu.sv
src/atomic_tx_table.sv
src/atomic_response_path.sv
src/atomic_mem_mux.sv
src/atomic_handler.sv
bench/atomic_handler_assertions.sv
bench/atomic_handler_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the atomic handler testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module atomic_handler_tb \
  -f atomic_handler.f || exit 1
out="$(./obj_dir/Vatomic_handler_tb 2>&1)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "^Simulation passed$" && exit 0 || exit 1
